/* design/pcie_pio_defs.svh */
`ifndef PCIE_PIO_DEFS_SVH
`define PCIE_PIO_DEFS_SVH

// qword register addresses
`define PIO_ADDR_STATUS   13'd0
`define PIO_ADDR_SCRATCH  13'd1
`define PIO_ADDR_COUNTS   13'd2
`define PIO_ADDR_LAST_CPL 13'd7

// fmt/type byte of DW0
// 3DW memory write with data
`define TLP_MWR64 8'h40
// 3DW memory read, no data
`define TLP_MRD   8'h00
// completion with data
`define TLP_CPLD  8'h4A

// pending completions held in front of the transmit stream
`define CPL_QUEUE_DEPTH 4

`endif

/* design/pcie_pio_pkg.sv */
package pcie_pio_pkg;

   // DW1 in the upper half, DW0 in the lower half, as on the 64-bit stream
   typedef struct packed {
      logic [15:0] requester_id;
      logic [7:0]  tag;
      logic [3:0]  last_be;
      logic [3:0]  first_be;
      logic [7:0]  fmt_type;
      // tc, attr, td, ep, at
      logic [13:0] rsvd0;
      logic [9:0]  length;
   } tlp_req_hdr_t;

   typedef struct packed {
      logic [15:0] completer_id;
      logic [2:0]  status;
      // bcm
      logic        rsvd1;
      logic [11:0] byte_count;
      logic [7:0]  fmt_type;
      logic [13:0] rsvd0;
      logic [9:0]  length;
   } tlp_cpl_hdr_t;

   // first beat of a TLP, read as a request or as a completion
   typedef union packed {
      tlp_req_hdr_t req;
      tlp_cpl_hdr_t cpl;
   } tlp_hdr_u;

   // one register read waiting to go out as a CplD
   typedef struct packed {
      // requester id and tag
      logic [23:0] rid_tag;
      // qword address low bits
      logic [3:0]  lower_addr;
      logic [63:0] data;
   } cpl_req_t;

endpackage

/* design/pio_bus_if.sv */
`timescale 1ns/1ps

interface pio_bus_if;

   // one-cycle strobes, never two at once
   logic        write_valid;
   logic        read_valid;
   logic        completion_valid;

   // qualified by the strobes
   logic [12:0] address;
   logic [63:0] data;
   logic [23:0] rid_tag;

   modport rx (
      output write_valid,
      output read_valid,
      output completion_valid,
      output address,
      output data,
      output rid_tag
   );

   modport regs (
      input write_valid,
      input read_valid,
      input completion_valid,
      input address,
      input data,
      input rid_tag
   );

endinterface

/* design/pcie_rx.sv */
`timescale 1ns/1ps
`include "pcie_pio_defs.svh"

module pcie_rx (
   input  logic        clock,
   input  logic        arst_n,
   input  logic        tvalid,
   input  logic        tlast,
   input  logic [63:0] tdata,
   pio_bus_if.rx       bus
);

   // beat index inside the current TLP, saturating at 3
   logic [1:0]             beat_cnt;
   pcie_pio_pkg::tlp_hdr_u hdr;

   logic is_write;
   logic is_read;
   logic is_cpl;

   // header beat was captured on beat 0, so later beats classify from it
   always_comb
   begin
      is_write = (hdr.req.fmt_type == `TLP_MWR64);
      is_read  = (hdr.req.fmt_type == `TLP_MRD);
      is_cpl   = (hdr.cpl.fmt_type == `TLP_CPLD);
   end

   always_ff @(posedge clock or negedge arst_n)
   begin
      if (!arst_n)
      begin
         beat_cnt             <= 2'd0;
         bus.write_valid      <= 1'b0;
         bus.read_valid       <= 1'b0;
         bus.completion_valid <= 1'b0;
      end
      else
      begin
         bus.write_valid      <= 1'b0;
         bus.read_valid       <= 1'b0;
         bus.completion_valid <= 1'b0;
         if (tvalid)
         begin
            if (tlast)
            begin
               beat_cnt <= 2'd0;
               // unknown codes and odd lengths fall through with no strobe
               if (beat_cnt == 2'd2)
               begin
                  bus.write_valid      <= is_write;
                  bus.completion_valid <= is_cpl;
               end
               if (beat_cnt == 2'd1)
                  bus.read_valid <= is_read;
            end
            else if (beat_cnt != 2'd3)
            begin
               beat_cnt <= beat_cnt + 2'd1;
            end
         end
      end
   end

   always_ff @(posedge clock)
   begin
      if (tvalid)
      begin
         case (beat_cnt)
            2'd0:
            begin
               hdr <= tdata;
            end
            2'd1:
            begin
               // DW2 low, first payload dword high
               bus.address     <= tdata[15:3];
               bus.data[31:0]  <= tdata[63:32];
               bus.rid_tag     <= {hdr.req.requester_id, hdr.req.tag};
            end
            2'd2:
            begin
               bus.data[63:32] <= tdata[31:0];
            end
            default:
            begin
            end
         endcase
      end
   end

endmodule

/* design/pio_regs.sv */
`timescale 1ns/1ps
`include "pcie_pio_defs.svh"

module pio_regs (
   input  logic                   clock,
   input  logic                   arst_n,
   pio_bus_if.regs                bus,
   input  logic [3:0]             irq_in,
   output logic                   cfg_interrupt,
   input  logic                   cfg_interrupt_rdy,
   output logic [3:0]             led,
   output logic                   cpl_valid,
   output pcie_pio_pkg::cpl_req_t cpl_req
);

   logic [3:0]  int_enable;
   logic [3:0]  irq_latch;
   logic [63:0] scratch;
   logic [63:0] last_cpl;
   logic [15:0] cpl_count;
   logic [15:0] write_count;
   logic [15:0] read_count;

   // read pipeline, first stage
   logic        read_done;
   logic [63:0] read_data;
   logic [23:0] read_rid_tag;
   logic [3:0]  read_lower_addr;
   logic [63:0] read_value;

   logic        status_read;

   assign led         = scratch[3:0];
   assign status_read = bus.read_valid && (bus.address == `PIO_ADDR_STATUS);

   always_comb
   begin
      case (bus.address)
         `PIO_ADDR_STATUS:   read_value = {56'd0, int_enable, irq_latch};
         `PIO_ADDR_SCRATCH:  read_value = scratch;
         `PIO_ADDR_COUNTS:   read_value = {16'd0, cpl_count, write_count, read_count};
         `PIO_ADDR_LAST_CPL: read_value = last_cpl;
         default:            read_value = 64'd0;
      endcase
   end

   always_ff @(posedge clock or negedge arst_n)
   begin
      if (!arst_n)
      begin
         int_enable    <= 4'd0;
         irq_latch     <= 4'd0;
         scratch       <= 64'd0;
         last_cpl      <= 64'd0;
         cpl_count     <= 16'd0;
         write_count   <= 16'd0;
         read_count    <= 16'd0;
         cfg_interrupt <= 1'b0;
         read_done     <= 1'b0;
         cpl_valid     <= 1'b0;
      end
      else
      begin
         if (bus.write_valid)
         begin
            case (bus.address)
               `PIO_ADDR_STATUS:  int_enable <= bus.data[3:0];
               `PIO_ADDR_SCRATCH: scratch    <= bus.data;
               default:
               begin
               end
            endcase
         end
         if (bus.completion_valid)
            last_cpl <= bus.data;

         cpl_count   <= cpl_count + {15'd0, bus.completion_valid};
         write_count <= write_count + {15'd0, bus.write_valid};
         read_count  <= read_count + {15'd0, bus.read_valid};

         // status read hands back the old latch, pulses of this cycle stay
         if (status_read)
            irq_latch <= irq_in;
         else
            irq_latch <= irq_latch | irq_in;

         if ((irq_in & int_enable) != 4'd0)
            cfg_interrupt <= 1'b1;
         else if (cfg_interrupt_rdy)
            cfg_interrupt <= 1'b0;

         read_done <= bus.read_valid;
         cpl_valid <= read_done;
      end
   end

   always_ff @(posedge clock)
   begin
      if (bus.read_valid)
      begin
         read_data       <= read_value;
         read_rid_tag    <= bus.rid_tag;
         read_lower_addr <= bus.address[3:0];
      end
      if (read_done)
      begin
         cpl_req.rid_tag    <= read_rid_tag;
         cpl_req.lower_addr <= read_lower_addr;
         cpl_req.data       <= read_data;
      end
   end

endmodule

/* design/pcie_tx.sv */
`timescale 1ns/1ps
`include "pcie_pio_defs.svh"

module pcie_tx (
   input  logic                   clock,
   input  logic                   arst_n,
   input  logic [15:0]            pcie_id,
   input  logic                   cpl_valid,
   input  pcie_pio_pkg::cpl_req_t cpl_req,
   input  logic                   tready,
   output logic                   tvalid,
   output logic [63:0]            tdata,
   output logic                   tlast,
   output logic                   one_dw
);

   localparam int PTR_W = $clog2(`CPL_QUEUE_DEPTH);

   // next beat to put on the stream
   localparam logic [1:0] S_HDR  = 2'd0;
   localparam logic [1:0] S_DW2  = 2'd1;
   localparam logic [1:0] S_DATA = 2'd2;

   pcie_pio_pkg::cpl_req_t queue [`CPL_QUEUE_DEPTH];
   logic [PTR_W-1:0]       wr_ptr;
   logic [PTR_W-1:0]       rd_ptr;
   logic [PTR_W:0]         count;

   logic [1:0]             state;
   pcie_pio_pkg::cpl_req_t cur;
   pcie_pio_pkg::tlp_hdr_u cpl_hdr;
   logic                   advance;
   logic                   pop;

   // output slot is empty or its beat is taken this cycle
   assign advance = !tvalid || tready;
   assign pop     = advance && (state == S_HDR) && (count != '0);

   always_comb
   begin
      cpl_hdr                  = '0;
      cpl_hdr.cpl.fmt_type     = `TLP_CPLD;
      cpl_hdr.cpl.length       = 10'd2;
      cpl_hdr.cpl.completer_id = pcie_id;
      cpl_hdr.cpl.status       = 3'd0;
      cpl_hdr.cpl.byte_count   = 12'd8;
   end

   always_ff @(posedge clock)
   begin
      if (cpl_valid)
         queue[wr_ptr] <= cpl_req;
      if (pop)
         cur <= queue[rd_ptr];
      if (advance)
      begin
         case (state)
            S_HDR:  tdata <= cpl_hdr;
            // lower address is a byte address, 8 bytes per qword
            S_DW2:  tdata <= {cur.data[31:0], cur.rid_tag, 1'b0, cur.lower_addr, 3'b000};
            default: tdata <= {32'd0, cur.data[63:32]};
         endcase
      end
   end

   always_ff @(posedge clock or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         state  <= S_HDR;
         tvalid <= 1'b0;
         tlast  <= 1'b0;
         one_dw <= 1'b0;
      end
      else
      begin
         if (cpl_valid)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + {{PTR_W{1'b0}}, cpl_valid} - {{PTR_W{1'b0}}, pop};

         if (advance)
         begin
            case (state)
               S_HDR:
               begin
                  tvalid <= pop;
                  tlast  <= 1'b0;
                  one_dw <= 1'b0;
                  if (pop)
                     state <= S_DW2;
               end
               S_DW2:
               begin
                  state <= S_DATA;
               end
               default:
               begin
                  tlast  <= 1'b1;
                  one_dw <= 1'b1;
                  state  <= S_HDR;
               end
            endcase
         end
      end
   end

endmodule

/* design/pcie_pio.sv */
`timescale 1ns/1ps

module pcie_pio (
   input  logic        clock,
   input  logic        arst_n,

   // receive stream from the PCIe core, always accepted
   input  logic        rx_tvalid,
   input  logic        rx_tlast,
   input  logic [63:0] rx_tdata,

   // transmit stream to the PCIe core
   output logic        tx_tvalid,
   input  logic        tx_tready,
   output logic [63:0] tx_tdata,
   output logic        tx_tlast,
   output logic        tx_1dw,

   input  logic [15:0] pcie_id,
   input  logic [3:0]  irq_in,
   output logic        cfg_interrupt,
   input  logic        cfg_interrupt_rdy,
   output logic [3:0]  led
);

   pio_bus_if bus ();

   logic                   cpl_valid;
   pcie_pio_pkg::cpl_req_t cpl_req;

   pcie_rx i_pcie_rx (
      .clock  (clock),
      .arst_n (arst_n),
      .tvalid (rx_tvalid),
      .tlast  (rx_tlast),
      .tdata  (rx_tdata),
      .bus    (bus.rx)
   );

   pio_regs i_pio_regs (
      .clock             (clock),
      .arst_n            (arst_n),
      .bus               (bus.regs),
      .irq_in            (irq_in),
      .cfg_interrupt     (cfg_interrupt),
      .cfg_interrupt_rdy (cfg_interrupt_rdy),
      .led               (led),
      .cpl_valid         (cpl_valid),
      .cpl_req           (cpl_req)
   );

   pcie_tx i_pcie_tx (
      .clock     (clock),
      .arst_n    (arst_n),
      .pcie_id   (pcie_id),
      .cpl_valid (cpl_valid),
      .cpl_req   (cpl_req),
      .tready    (tx_tready),
      .tvalid    (tx_tvalid),
      .tdata     (tx_tdata),
      .tlast     (tx_tlast),
      .one_dw    (tx_1dw)
   );

endmodule

/* test/tb_pcie_pio.sv */
`timescale 1ns/1ps
`include "pcie_pio_defs.svh"

module tb_pcie_pio;

   localparam int N_TXN        = 300;
   // cplD plus follow-up read plus an irq pulse and acknowledge
   localparam int WORST_CYCLES = 16;
   localparam int STALL_MARGIN = 4;
   localparam int TIMEOUT_NS   = (N_TXN * WORST_CYCLES * STALL_MARGIN + 10) * 40;

   logic        clock = 1'b0;
   logic        arst_n = 1'b0;
   logic        rx_tvalid = 1'b0;
   logic        rx_tlast = 1'b0;
   logic [63:0] rx_tdata = 64'd0;
   logic        tx_tready = 1'b0;
   logic [15:0] pcie_id = 16'd0;
   logic [3:0]  irq_in = 4'd0;
   logic        cfg_interrupt_rdy = 1'b0;
   logic        tx_tvalid;
   logic        tx_tlast;
   logic        tx_1dw;
   logic        cfg_interrupt;
   logic [63:0] tx_tdata;
   logic [3:0]  led;

   logic [31:0] rng_state = 32'h814c_69e8;
   logic [31:0] stall_state = ~32'h814c_69e8;

   // reference model of the register block
   logic [63:0] scratch_m = 64'd0;
   logic [63:0] last_cpl_m = 64'd0;
   logic [3:0]  enable_m = 4'd0;
   logic [3:0]  latch_m = 4'd0;
   logic        cfg_int_m = 1'b0;
   logic [15:0] cpl_cnt_m = 16'd0;
   logic [15:0] wr_cnt_m = 16'd0;
   logic [15:0] rd_cnt_m = 16'd0;
   // three beats per expected completion in request order
   logic [63:0] exp_beats [$];

   logic        stalled = 1'b0;
   logic [65:0] held = 66'd0;
   logic [1:0]  beat_idx = 2'd0;
   logic [63:0] exp_beat;

   pcie_pio i_pcie_pio (.*);

   always #20 clock = ~clock;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = lcg_step(rng_state);
      return rng_state;
   endfunction

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("ERRORS FOUND");
      $fatal(1, "run stopped at first failure");
   endtask

   task automatic compare_value(input string name, input logic [63:0] actual,
                                input logic [63:0] expected);
      if (actual !== expected)
         fail_run($sformatf("MISMATCH at time %0t: %s is %h, expected %h",
                            $time, name, actual, expected));
   endtask

   // mapped addresses are drawn more often than random ones
   function automatic logic [12:0] pick_addr(input logic [31:0] r);
      case (r[31:29])
         3'd0:       return `PIO_ADDR_STATUS;
         3'd1, 3'd2: return `PIO_ADDR_SCRATCH;
         3'd3:       return `PIO_ADDR_COUNTS;
         3'd4:       return `PIO_ADDR_LAST_CPL;
         default:    return r[12:0];
      endcase
   endfunction

   function automatic logic [63:0] model_read(input logic [12:0] addr);
      logic [63:0] value;
      case (addr)
         `PIO_ADDR_STATUS:
         begin
            value   = {56'd0, enable_m, latch_m};
            latch_m = 4'd0;
         end
         `PIO_ADDR_SCRATCH:  value = scratch_m;
         `PIO_ADDR_COUNTS:   value = {16'd0, cpl_cnt_m, wr_cnt_m, rd_cnt_m};
         `PIO_ADDR_LAST_CPL: value = last_cpl_m;
         default:            value = 64'd0;
      endcase
      rd_cnt_m = rd_cnt_m + 16'd1;
      return value;
   endfunction

   // beat 0 in the low qword and two idle cycles so the strobe has landed
   task automatic send_tlp(input logic [191:0] tlp, input int beats);
      int i;
      for (i = 0; i < beats; i++)
      begin
         @(negedge clock);
         rx_tvalid = 1'b1;
         rx_tlast  = (i == beats - 1);
         rx_tdata  = tlp[64*i +: 64];
      end
      @(negedge clock);
      rx_tvalid = 1'b0;
      rx_tlast  = 1'b0;
      @(negedge clock);
   endtask

   task automatic write_register(input logic [12:0] addr, input logic [63:0] data);
      wr_cnt_m = wr_cnt_m + 16'd1;
      if (addr == `PIO_ADDR_STATUS)
         enable_m = data[3:0];
      if (addr == `PIO_ADDR_SCRATCH)
         scratch_m = data;
      send_tlp({32'd0, data[63:32], data[31:0], 16'd0, addr, 3'b000,
                32'h0100_000F, `TLP_MWR64, 24'd2}, 3);
      compare_value("led", led, scratch_m[3:0]);
   endtask

   task automatic inject_completion(input logic [63:0] data, input logic [23:0] rid_tag);
      cpl_cnt_m  = cpl_cnt_m + 16'd1;
      last_cpl_m = data;
      send_tlp({32'd0, data[63:32], data[31:0], rid_tag, 8'd0,
                16'h0200, 4'd0, 12'd8, `TLP_CPLD, 24'd2}, 3);
   endtask

   task automatic read_register(input logic [12:0] addr);
      logic [31:0] r;
      logic [63:0] value;
      while (exp_beats.size() >= 3 * `CPL_QUEUE_DEPTH)
         @(negedge clock);
      r     = next_rand();
      value = model_read(addr);
      exp_beats.push_back({pcie_id, 4'd0, 12'd8, `TLP_CPLD, 14'd0, 10'd2});
      exp_beats.push_back({value[31:0], r[31:8], 1'b0, addr[3:0], 3'b000});
      exp_beats.push_back({32'd0, value[63:32]});
      send_tlp({64'd0, 32'd0, 16'd0, addr, 3'b000, r[31:8], 8'h0F, `TLP_MRD, 24'd2}, 2);
   endtask

   task automatic pulse_irq(input logic [3:0] pulse);
      @(negedge clock);
      irq_in  = pulse;
      latch_m = latch_m | pulse;
      if ((pulse & enable_m) != 4'd0)
         cfg_int_m = 1'b1;
      @(negedge clock);
      irq_in = 4'd0;
      compare_value("cfg_interrupt", cfg_interrupt, cfg_int_m);
      // host acknowledges one cycle later
      if (cfg_int_m)
      begin
         @(negedge clock);
         compare_value("cfg_interrupt", cfg_interrupt, cfg_int_m);
         cfg_interrupt_rdy = 1'b1;
         @(negedge clock);
         cfg_interrupt_rdy = 1'b0;
         cfg_int_m         = 1'b0;
         compare_value("cfg_interrupt", cfg_interrupt, cfg_int_m);
      end
   endtask

   // hold check on a stall and a fresh tready for the next edge
   always @(negedge clock)
   begin
      if (stalled)
      begin
         compare_value("tx_tvalid", tx_tvalid, 1'b1);
         compare_value("tx_tdata", tx_tdata, held[63:0]);
         compare_value("tx_tlast", tx_tlast, held[65]);
         compare_value("tx_1dw", tx_1dw, held[64]);
      end
      stall_state = lcg_step(stall_state);
      tx_tready   = (stall_state[31:30] != 2'b00);
      stalled     = tx_tvalid && !tx_tready;
      held        = {tx_tlast, tx_1dw, tx_tdata};
      if (tx_tvalid && tx_tready)
      begin
         if (exp_beats.size() == 0)
            fail_run("a completion beat was sent with no read outstanding");
         else
         begin
            exp_beat = exp_beats.pop_front();
            compare_value("tx_tdata", tx_tdata, exp_beat);
            compare_value("tx_tlast", tx_tlast, beat_idx == 2'd2);
            compare_value("tx_1dw", tx_1dw, beat_idx == 2'd2);
            beat_idx = (beat_idx == 2'd2) ? 2'd0 : beat_idx + 2'd1;
         end
      end
   end

   initial
   begin
      #(TIMEOUT_NS);
      fail_run("watchdog expired before all transactions finished");
   end

   initial
   begin
      logic [31:0] r;
      logic [63:0] data;
      int          n;
      r       = next_rand();
      pcie_id = r[31:16];
      repeat (10) @(negedge clock);
      arst_n = 1'b1;
      compare_value("tx_tvalid", tx_tvalid, 1'b0);
      compare_value("cfg_interrupt", cfg_interrupt, 1'b0);
      compare_value("led", led, 4'd0);
      for (n = 0; n < N_TXN; n++)
      begin
         r    = next_rand();
         data = {next_rand(), next_rand()};
         case (r[31:29])
            3'd0, 3'd1, 3'd2: write_register(pick_addr(next_rand()), data);
            3'd3, 3'd4, 3'd5: read_register(pick_addr(next_rand()));
            3'd6:
            begin
               inject_completion(data, r[23:0]);
               read_register(`PIO_ADDR_LAST_CPL);
            end
            // 4DW request codes the parser does not know
            default: send_tlp({data, data, 32'd0, (r[20] ? 8'h60 : 8'h20), 24'd2}, 3);
         endcase
         if (r[28:27] == 2'd0)
            pulse_irq(r[26:23]);
      end
      while (exp_beats.size() != 0)
         @(negedge clock);
      repeat (8) @(negedge clock);
      compare_value("tx_tvalid", tx_tvalid, 1'b0);
      $display("NO ERRORS");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+design
design/pcie_pio_pkg.sv
design/pio_bus_if.sv
design/pcie_rx.sv
design/pio_regs.sv
design/pcie_tx.sv
design/pcie_pio.sv
test/tb_pcie_pio.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then scan the log for the fail message
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_pcie_pio \
   && { ./obj_dir/Vtb_pcie_pio > sim.log 2>&1; cat sim.log; } \
   && ! grep -q "ERRORS FOUND" sim.log \
   && grep -q "NO ERRORS" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
